// File: common/rasterPkg.sv
// Command layout and shared types; coordinates are 8 bit, so a screen is at most 256x256
package rasterPkg;

    localparam int CmdWidth = 32;
    localparam int NumEdges = 3;

    typedef logic [15:0] color_t;
    typedef logic signed [15:0] edge_t;
    typedef logic [7:0] coord_t;

    typedef enum logic [3:0] {
        opNop, opSetReg, opRender, opClear, opCommit
    } cmdOpcode_t;

    typedef enum logic [3:0] {
        regBbStartX, regBbStartY, regBbEndX, regBbEndY,
        regW0, regW1, regW2,
        regW0IncX, regW1IncX, regW2IncX,
        regW0IncY, regW1IncY, regW2IncY,
        regTriangleColor, regClearColor
    } regIndex_t;

    ////////////////////////////////////////
    // One command word
    ////////////////////////////////////////
    typedef struct packed {
        cmdOpcode_t   opcode;   // 31:28
        regIndex_t    index;    // 27:24
        logic [7:0]   unused;
        logic [15:0]  value;    // 15:0
    } cmdWord_t;

    typedef enum logic [1:0] {psIdle, psLaunch, psWait} parserState_t;
    typedef enum logic [1:0] {bsIdle, bsClearing, bsStreaming} bufferState_t;

endpackage

// File: common/scanIf.sv
// Walker to evaluator and color buffer link; fragment fields lag load/step by one cycle
`timescale 1ns/1ps

interface scanIf #(
    parameter int IndexWidth = 8
);
    logic                    load;
    logic                    stepX;
    logic                    stepY;
    logic                    fragValid;
    logic [IndexWidth-1:0]   fragIndex;

    modport walker (output load, stepX, stepY, fragValid, fragIndex);

    // Edge evaluators only follow the walk commands
    modport edgeEval (input load, stepX, stepY);

    modport sink (input fragValid, fragIndex);
endinterface

// File: design/colorBuffer.sv
// Single-port pixel store; clear, fragment writes and commit never overlap
`timescale 1ns/1ps

module colorBuffer #(
    parameter int XRes = 16,
    parameter int YRes = 16
) (
    input  logic                          aclk,
    input  logic                          rst,
    input  logic                          startClear,
    input  logic                          startCommit,
    scanIf.sink                           scan,
    input  logic [rasterPkg::NumEdges-1:0] insideMask,
    input  rasterPkg::color_t             triangleColor,
    input  rasterPkg::color_t             clearColor,
    output logic                          bufferBusy,
    output logic                          fbTvalid,
    input  logic                          fbTready,
    output logic                          fbTlast,
    output rasterPkg::color_t             fbTdata
);

    localparam int PixelCount = XRes * YRes;
    localparam int IndexWidth = $clog2(PixelCount);
    localparam logic [IndexWidth-1:0] LastIndex = IndexWidth'(PixelCount - 1);

    rasterPkg::color_t        mem [PixelCount];
    rasterPkg::bufferState_t  state;
    logic [IndexWidth-1:0]    addr;
    logic                     loadWord;
    logic                     fragWrite;

    assign bufferBusy = (state != rasterPkg::bsIdle);
    assign fragWrite  = scan.fragValid && (&insideMask);

    // Fetch the next word when the output register is empty or draining
    assign loadWord = (state == rasterPkg::bsStreaming) && !(fbTvalid && fbTlast)
                      && (!fbTvalid || fbTready);

    ////////////////////////////////////////
    // Pixel memory
    ////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (state == rasterPkg::bsClearing) begin
            mem[addr] <= clearColor;
        end else if (fragWrite) begin
            mem[scan.fragIndex] <= triangleColor;
        end
        if (loadWord) begin
            fbTdata <= mem[addr];
        end
    end

    ////////////////////////////////////////
    // Clear and commit control
    ////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (rst) begin
            state    <= rasterPkg::bsIdle;
            addr     <= '0;
            fbTvalid <= 1'b0;
            fbTlast  <= 1'b0;
        end else begin
            case (state)
                rasterPkg::bsIdle: begin
                    addr <= '0;
                    if (startClear) begin
                        state <= rasterPkg::bsClearing;
                    end else if (startCommit) begin
                        state <= rasterPkg::bsStreaming;
                    end
                end
                rasterPkg::bsClearing: begin
                    addr <= addr + 1'b1;
                    if (addr == LastIndex) begin
                        state <= rasterPkg::bsIdle;
                    end
                end
                rasterPkg::bsStreaming: begin
                    if (loadWord) begin
                        fbTvalid <= 1'b1;
                        fbTlast  <= (addr == LastIndex);
                        addr     <= addr + 1'b1;
                    end else if (fbTvalid && fbTready) begin
                        // Only the last word can leave without a refill
                        fbTvalid <= 1'b0;
                        fbTlast  <= 1'b0;
                        state    <= rasterPkg::bsIdle;
                    end
                end
                default: state <= rasterPkg::bsIdle;
            endcase
        end
    end

endmodule

// File: design/commandParser.sv
// Command decoder and register bank; stalls the stream until a started action reports idle
`timescale 1ns/1ps

module commandParser (
    input  logic                               aclk,
    input  logic                               rst,
    input  logic                               cmdTvalid,
    output logic                               cmdTready,
    input  logic [rasterPkg::CmdWidth-1:0]     cmdTdata,
    input  logic                               renderBusy,
    input  logic                               bufferBusy,
    output logic                               startRender,
    output logic                               startClear,
    output logic                               startCommit,
    output rasterPkg::coord_t                  bbStartX,
    output rasterPkg::coord_t                  bbStartY,
    output rasterPkg::coord_t                  bbEndX,
    output rasterPkg::coord_t                  bbEndY,
    output rasterPkg::edge_t                   edgeInit [rasterPkg::NumEdges],
    output rasterPkg::edge_t                   edgeIncX [rasterPkg::NumEdges],
    output rasterPkg::edge_t                   edgeIncY [rasterPkg::NumEdges],
    output rasterPkg::color_t                  triangleColor,
    output rasterPkg::color_t                  clearColor
);

    rasterPkg::cmdWord_t      cmd;
    rasterPkg::parserState_t  state;
    rasterPkg::cmdOpcode_t    pendingOp;
    logic                     accept;
    logic                     isAction;
    logic                     actionBusy;

    assign cmd        = rasterPkg::cmdWord_t'(cmdTdata);
    assign cmdTready  = (state == rasterPkg::psIdle);
    assign accept     = cmdTvalid && cmdTready;
    assign isAction   = cmd.opcode inside {rasterPkg::opRender, rasterPkg::opClear,
                                           rasterPkg::opCommit};
    assign actionBusy = (pendingOp == rasterPkg::opRender) ? renderBusy : bufferBusy;

    // One start pulse per action, issued from the launch state
    assign startRender = (state == rasterPkg::psLaunch) && (pendingOp == rasterPkg::opRender);
    assign startClear  = (state == rasterPkg::psLaunch) && (pendingOp == rasterPkg::opClear);
    assign startCommit = (state == rasterPkg::psLaunch) && (pendingOp == rasterPkg::opCommit);

    always_ff @(posedge aclk) begin
        if (rst) begin
            state     <= rasterPkg::psIdle;
            pendingOp <= rasterPkg::opNop;
        end else begin
            case (state)
                rasterPkg::psIdle: begin
                    if (accept && isAction) begin
                        pendingOp <= cmd.opcode;
                        state     <= rasterPkg::psLaunch;
                    end
                end
                // Busy is only valid from the cycle after the pulse
                rasterPkg::psLaunch: state <= rasterPkg::psWait;
                rasterPkg::psWait: begin
                    if (!actionBusy) begin
                        state <= rasterPkg::psIdle;
                    end
                end
                default: state <= rasterPkg::psIdle;
            endcase
        end
    end

    ////////////////////////////////////////
    // Register bank
    ////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (accept && (cmd.opcode == rasterPkg::opSetReg)) begin
            case (cmd.index)
                rasterPkg::regBbStartX:      bbStartX <= cmd.value[7:0];
                rasterPkg::regBbStartY:      bbStartY <= cmd.value[7:0];
                rasterPkg::regBbEndX:        bbEndX <= cmd.value[7:0];
                rasterPkg::regBbEndY:        bbEndY <= cmd.value[7:0];
                rasterPkg::regW0:            edgeInit[0] <= cmd.value;
                rasterPkg::regW1:            edgeInit[1] <= cmd.value;
                rasterPkg::regW2:            edgeInit[2] <= cmd.value;
                rasterPkg::regW0IncX:        edgeIncX[0] <= cmd.value;
                rasterPkg::regW1IncX:        edgeIncX[1] <= cmd.value;
                rasterPkg::regW2IncX:        edgeIncX[2] <= cmd.value;
                rasterPkg::regW0IncY:        edgeIncY[0] <= cmd.value;
                rasterPkg::regW1IncY:        edgeIncY[1] <= cmd.value;
                rasterPkg::regW2IncY:        edgeIncY[2] <= cmd.value;
                rasterPkg::regTriangleColor: triangleColor <= cmd.value;
                rasterPkg::regClearColor:    clearColor <= cmd.value;
                default: ;
            endcase
        end
    end

endmodule

// File: design/rasterLite.sv
// Triangle renderer top; flat color only, one command per 32-bit word, XRes and YRes up to 256
`timescale 1ns/1ps

module rasterLite #(
    parameter int XRes = 16,
    parameter int YRes = 16
) (
    input  logic                           aclk,
    input  logic                           rst,
    input  logic                           cmdTvalid,
    output logic                           cmdTready,
    input  logic [rasterPkg::CmdWidth-1:0] cmdTdata,
    output logic                           fbTvalid,
    input  logic                           fbTready,
    output logic                           fbTlast,
    output rasterPkg::color_t              fbTdata,
    output logic                           rasterizerRunning
);

    localparam int IndexWidth = $clog2(XRes * YRes);

    logic                            renderBusy;
    logic                            bufferBusy;
    logic                            startRender;
    logic                            startClear;
    logic                            startCommit;
    rasterPkg::coord_t               bbStartX;
    rasterPkg::coord_t               bbStartY;
    rasterPkg::coord_t               bbEndX;
    rasterPkg::coord_t               bbEndY;
    rasterPkg::edge_t                edgeInit [rasterPkg::NumEdges];
    rasterPkg::edge_t                edgeIncX [rasterPkg::NumEdges];
    rasterPkg::edge_t                edgeIncY [rasterPkg::NumEdges];
    rasterPkg::color_t               triangleColor;
    rasterPkg::color_t               clearColor;
    logic [rasterPkg::NumEdges-1:0]  insideMask;

    scanIf #(.IndexWidth(IndexWidth)) scan ();

    commandParser uParser (
        .aclk(aclk), .rst(rst),
        .cmdTvalid(cmdTvalid), .cmdTready(cmdTready), .cmdTdata(cmdTdata),
        .renderBusy(renderBusy), .bufferBusy(bufferBusy),
        .startRender(startRender), .startClear(startClear), .startCommit(startCommit),
        .bbStartX(bbStartX), .bbStartY(bbStartY), .bbEndX(bbEndX), .bbEndY(bbEndY),
        .edgeInit(edgeInit), .edgeIncX(edgeIncX), .edgeIncY(edgeIncY),
        .triangleColor(triangleColor), .clearColor(clearColor)
    );

    scanWalker #(.XRes(XRes), .YRes(YRes)) uWalker (
        .aclk(aclk), .rst(rst), .startRender(startRender),
        .bbStartX(bbStartX), .bbStartY(bbStartY), .bbEndX(bbEndX), .bbEndY(bbEndY),
        .renderBusy(renderBusy), .rasterizerRunning(rasterizerRunning),
        .scan(scan)
    );

    // One evaluator per triangle edge
    for (genvar i = 0; i < rasterPkg::NumEdges; i++) begin : gEdge
        edgeEvaluator uEdge (
            .aclk(aclk), .rst(rst), .scan(scan),
            .init(edgeInit[i]), .incX(edgeIncX[i]), .incY(edgeIncY[i]),
            .isInside(insideMask[i])
        );
    end

    colorBuffer #(.XRes(XRes), .YRes(YRes)) uBuffer (
        .aclk(aclk), .rst(rst),
        .startClear(startClear), .startCommit(startCommit),
        .scan(scan), .insideMask(insideMask),
        .triangleColor(triangleColor), .clearColor(clearColor),
        .bufferBusy(bufferBusy),
        .fbTvalid(fbTvalid), .fbTready(fbTready), .fbTlast(fbTlast), .fbTdata(fbTdata)
    );

endmodule

// File: rasterLite.f
common/rasterPkg.sv
common/scanIf.sv
design/commandParser.sv
rasterizer/scanWalker.sv
rasterizer/edgeEvaluator.sv
design/colorBuffer.sv
design/rasterLite.sv
tests/clockGen.sv
tests/rasterLiteTb.sv

// File: rasterizer/edgeEvaluator.sv
// Incremental edge function; sums wrap at 16 bit, so callers keep values in range
`timescale 1ns/1ps

module edgeEvaluator (
    input  logic              aclk,
    input  logic              rst,
    scanIf.edgeEval           scan,
    input  rasterPkg::edge_t  init,
    input  rasterPkg::edge_t  incX,
    input  rasterPkg::edge_t  incY,
    output logic              isInside
);

    rasterPkg::edge_t rowStart;
    rasterPkg::edge_t current;
    rasterPkg::edge_t nextRow;

    assign nextRow = rowStart + incY;

    always_ff @(posedge aclk) begin
        if (rst) begin
            rowStart <= '0;
            current  <= '0;
        end else if (scan.load) begin
            rowStart <= init;
            current  <= init;
        end else if (scan.stepY) begin
            rowStart <= nextRow;
            current  <= nextRow;
        end else if (scan.stepX) begin
            current <= current + incX;
        end
    end

    // Non-negative means inside the half plane
    assign isInside = !current[15];

endmodule

// File: rasterizer/scanWalker.sv
// Raster-order box walk, one pixel per cycle; box end is exclusive and clipped to XRes x YRes
`timescale 1ns/1ps

module scanWalker #(
    parameter int XRes = 16,
    parameter int YRes = 16
) (
    input  logic               aclk,
    input  logic               rst,
    input  logic               startRender,
    input  rasterPkg::coord_t  bbStartX,
    input  rasterPkg::coord_t  bbStartY,
    input  rasterPkg::coord_t  bbEndX,
    input  rasterPkg::coord_t  bbEndY,
    output logic               renderBusy,
    output logic               rasterizerRunning,
    scanIf.walker              scan
);

    localparam int IndexWidth = $clog2(XRes * YRes);
    localparam logic [8:0] XLimit = 9'(XRes);
    localparam logic [8:0] YLimit = 9'(YRes);

    typedef enum logic [1:0] {walkIdle, walkScan, walkDrain} walkState_t;

    walkState_t         state;
    rasterPkg::coord_t  cx;
    rasterPkg::coord_t  cy;
    logic               first;
    logic [8:0]         endX;
    logic [8:0]         endY;
    logic               emptyBox;
    logic               lastCol;
    logic               lastRow;

    // Clip the box end to the screen
    assign endX     = ({1'b0, bbEndX} > XLimit) ? XLimit : {1'b0, bbEndX};
    assign endY     = ({1'b0, bbEndY} > YLimit) ? YLimit : {1'b0, bbEndY};
    assign emptyBox = ({1'b0, bbStartX} >= endX) || ({1'b0, bbStartY} >= endY);
    assign lastCol  = ({1'b0, cx} == endX - 9'd1);
    assign lastRow  = ({1'b0, cy} == endY - 9'd1);

    // Walk commands for the pixel at (cx, cy)
    assign scan.load  = (state == walkScan) && first;
    assign scan.stepY = (state == walkScan) && !first && (cx == bbStartX);
    assign scan.stepX = (state == walkScan) && !first && (cx != bbStartX);

    assign renderBusy        = (state != walkIdle);
    assign rasterizerRunning = renderBusy;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state          <= walkIdle;
            cx             <= '0;
            cy             <= '0;
            first          <= 1'b0;
            scan.fragValid <= 1'b0;
        end else begin
            scan.fragValid <= (state == walkScan);
            case (state)
                walkIdle: begin
                    if (startRender) begin
                        cx    <= bbStartX;
                        cy    <= bbStartY;
                        first <= 1'b1;
                        state <= emptyBox ? walkDrain : walkScan;
                    end
                end
                walkScan: begin
                    first <= 1'b0;
                    if (lastCol) begin
                        cx <= bbStartX;
                        if (lastRow) begin
                            state <= walkDrain;
                        end else begin
                            cy <= cy + 8'd1;
                        end
                    end else begin
                        cx <= cx + 8'd1;
                    end
                end
                // last fragment is written while we sit here
                walkDrain: state <= walkIdle;
                default: state <= walkIdle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        scan.fragIndex <= IndexWidth'(cy * XRes + cx);
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f rasterLite.f --top-module rasterLiteTb
if [ $? -ne 0 ]; then
    echo "Verilator build did not complete"
    exit 1
fi

simOut=$(./obj_dir/VrasterLiteTb)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

// File: tests/clockGen.sv
// Free-running clock and an active-high synchronous reset held for ResetCycles rising edges
`timescale 1ns/1ps

module clockGen #(
    parameter int Period      = 40,
    parameter int ResetCycles = 4
) (
    output logic aclk,
    output logic rst
);

    initial begin
        aclk = 1'b0;
        forever #(Period / 2) aclk = ~aclk;
    end

    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge aclk);
        rst <= 1'b0;
    end

endmodule

// File: tests/rasterLiteTb.sv
// Directed tests for the 16x16 build; edge values must stay inside 16-bit signed range
`timescale 1ns/1ps

module rasterLiteTb;

    localparam int XRes       = 16;
    localparam int YRes       = 16;
    localparam int PixelCount = XRes * YRes;
    localparam int WaitLimit  = 2000;

    logic         aclk;
    logic         rst;
    logic         cmdTvalid;
    logic         cmdTready;
    logic [31:0]  cmdTdata;
    logic         fbTvalid;
    logic         fbTready;
    logic         fbTlast;
    logic [15:0]  fbTdata;
    logic         rasterizerRunning;

    // Reference frame and the triangle last sent
    logic [15:0]  model [PixelCount];
    int           boxX0;
    int           boxY0;
    int           boxX1;
    int           boxY1;
    int           triInit [3];
    int           triIncX [3];
    int           triIncY [3];
    logic [15:0]  triColor;

    int           errorCount;
    int           testCount;
    int           overlapErrors;
    logic         timedOut;
    logic         watchRunning;
    logic         sawRunning;

    clockGen #(.Period(40), .ResetCycles(4)) uClock (.aclk(aclk), .rst(rst));

    rasterLite #(.XRes(XRes), .YRes(YRes)) uut (
        .aclk(aclk), .rst(rst),
        .cmdTvalid(cmdTvalid), .cmdTready(cmdTready), .cmdTdata(cmdTdata),
        .fbTvalid(fbTvalid), .fbTready(fbTready), .fbTlast(fbTlast), .fbTdata(fbTdata),
        .rasterizerRunning(rasterizerRunning)
    );

    // Command stream must stall for the whole render
    always @(posedge aclk) begin
        if (watchRunning && rasterizerRunning) begin
            sawRunning = 1'b1;
            if (cmdTready) begin
                $display("ERR %0t: cmdTready high while rasterizer running", $time);
                overlapErrors++;
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////
    function automatic logic [31:0] mkCmd(input logic [3:0] opcode, input logic [3:0] index,
                                          input logic [15:0] value);
        return {opcode, index, 8'h00, value};
    endfunction

    task automatic waitReset();
        int waitCycles;
        waitCycles = 0;
        @(posedge aclk);
        while (rst !== 1'b0 && !timedOut) begin
            waitCycles++;
            if (waitCycles > WaitLimit) begin
                $display("Timeout: reset was never released");
                timedOut = 1'b1;
                errorCount++;
            end else begin
                @(posedge aclk);
            end
        end
    endtask

    // Leaves cmdTvalid high so commands can follow back to back
    task automatic sendCmd(input logic [31:0] word);
        int waitCycles;
        waitCycles = 0;
        if (!timedOut) begin
            cmdTvalid <= 1'b1;
            cmdTdata  <= word;
            @(posedge aclk);
            while (!cmdTready && !timedOut) begin
                waitCycles++;
                if (waitCycles > WaitLimit) begin
                    $display("Timeout at %0t: command stream never became ready", $time);
                    timedOut = 1'b1;
                    errorCount++;
                end else begin
                    @(posedge aclk);
                end
            end
        end
    endtask

    task automatic releaseCmd();
        cmdTvalid <= 1'b0;
    endtask

    task automatic setReg(input logic [3:0] index, input logic [15:0] value);
        sendCmd(mkCmd(rasterPkg::opSetReg, index, value));
    endtask

    task automatic defineEdge(input int e, input int init, input int incX, input int incY);
        triInit[e] = init;
        triIncX[e] = incX;
        triIncY[e] = incY;
    endtask

    task automatic sendTriangle();
        setReg(rasterPkg::regBbStartX, 16'(boxX0));
        setReg(rasterPkg::regBbStartY, 16'(boxY0));
        setReg(rasterPkg::regBbEndX, 16'(boxX1));
        setReg(rasterPkg::regBbEndY, 16'(boxY1));
        for (int e = 0; e < 3; e++) begin
            setReg(4'(rasterPkg::regW0 + e), 16'(triInit[e]));
            setReg(4'(rasterPkg::regW0IncX + e), 16'(triIncX[e]));
            setReg(4'(rasterPkg::regW0IncY + e), 16'(triIncY[e]));
        end
        setReg(rasterPkg::regTriangleColor, triColor);
        sendCmd(mkCmd(rasterPkg::opRender, 4'h0, 16'h0));
    endtask

    task automatic clearFrame(input logic [15:0] color);
        setReg(rasterPkg::regClearColor, color);
        sendCmd(mkCmd(rasterPkg::opClear, 4'h0, 16'h0));
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic void modelClear(input logic [15:0] color);
        for (int i = 0; i < PixelCount; i++) begin
            model[i] = color;
        end
    endfunction

    function automatic void modelRender();
        int  xEnd;
        int  yEnd;
        int  w;
        bit  covered;
        xEnd = (boxX1 > XRes) ? XRes : boxX1;
        yEnd = (boxY1 > YRes) ? YRes : boxY1;
        for (int y = boxY0; y < yEnd; y++) begin
            for (int x = boxX0; x < xEnd; x++) begin
                covered = 1'b1;
                for (int e = 0; e < 3; e++) begin
                    w = triInit[e] + (x - boxX0) * triIncX[e] + (y - boxY0) * triIncY[e];
                    if (w < 0) covered = 1'b0;
                end
                if (covered) model[y * XRes + x] = triColor;
            end
        end
    endfunction

    // Reads one full frame and compares it word by word with the model
    task automatic collectFrame(input bit randomReady);
        int  waitCycles;
        bit  got;
        for (int i = 0; i < PixelCount; i++) begin
            got = 1'b0;
            waitCycles = 0;
            while (!got && !timedOut) begin
                fbTready <= randomReady ? (($urandom % 2) != 0) : 1'b1;
                @(posedge aclk);
                if (fbTvalid && fbTready) begin
                    got = 1'b1;
                end else begin
                    waitCycles++;
                    if (waitCycles > WaitLimit) begin
                        $display("Timeout at %0t: output word %0d never arrived", $time, i);
                        timedOut = 1'b1;
                        errorCount++;
                    end
                end
            end
            if (got) begin
                if (fbTdata !== model[i]) begin
                    $display("ERR %0t: pixel %0d is %h, expected %h", $time, i, fbTdata,
                             model[i]);
                    errorCount++;
                end
                if (fbTlast !== (i == PixelCount - 1)) begin
                    $display("ERR %0t: fbTlast is %b on word %0d", $time, fbTlast, i);
                    errorCount++;
                end
            end
        end
        fbTready <= 1'b0;
    endtask

    task automatic commitAndCheck(input bit randomReady);
        sendCmd(mkCmd(rasterPkg::opCommit, 4'h0, 16'h0));
        releaseCmd();
        collectFrame(randomReady);
    endtask

    task automatic reportTest(input string name, input int startErrors);
        testCount++;
        if (errorCount == startErrors) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errorCount - startErrors);
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    task automatic testClearCommit();
        int           startErrors;
        logic [15:0]  color;
        startErrors = errorCount;
        color = 16'($urandom);
        clearFrame(color);
        modelClear(color);
        commitAndCheck(1'b0);
        reportTest("clear then commit", startErrors);
    endtask

    task automatic testBoxOnly();
        int           startErrors;
        logic [15:0]  color;
        startErrors = errorCount;
        color = 16'($urandom);
        clearFrame(color);
        modelClear(color);
        // End past the right edge, so the walker must clip
        boxX0 = 3;
        boxY0 = 4;
        boxX1 = 20;
        boxY1 = 9;
        for (int e = 0; e < 3; e++) defineEdge(e, 0, 0, 0);
        triColor = color ^ 16'hffff;
        sendTriangle();
        releaseCmd();
        modelRender();
        commitAndCheck(1'b0);
        reportTest("box only render", startErrors);
    endtask

    task automatic testDiagonal();
        int startErrors;
        startErrors = errorCount;
        boxX0 = 2;
        boxY0 = 2;
        boxX1 = 14;
        boxY1 = 12;
        defineEdge(0, 0, 1, -1);
        defineEdge(1, 5, 0, 0);
        defineEdge(2, 5, 0, 0);
        triColor = 16'($urandom);
        sendTriangle();
        releaseCmd();
        modelRender();
        commitAndCheck(1'b0);
        reportTest("diagonal edge", startErrors);
    endtask

    task automatic testRandomReady();
        int startErrors;
        startErrors = errorCount;
        commitAndCheck(1'b1);
        reportTest("commit with random fbTready", startErrors);
    endtask

    task automatic testBackToBack();
        int           startErrors;
        logic [15:0]  color;
        startErrors = errorCount;
        color = 16'($urandom);
        boxX0 = 1;
        boxY0 = 1;
        boxX1 = 15;
        boxY1 = 15;
        defineEdge(0, 10, -1, -1);
        defineEdge(1, -2, 1, 0);
        defineEdge(2, 2, 0, 1);
        triColor = color ^ 16'h5a5a;
        sawRunning = 1'b0;
        overlapErrors = 0;
        watchRunning = 1'b1;
        // cmdTvalid stays high from the clear through the render
        clearFrame(color);
        sendTriangle();
        releaseCmd();
        modelClear(color);
        modelRender();
        commitAndCheck(1'b0);
        watchRunning = 1'b0;
        errorCount += overlapErrors;
        if (!sawRunning) begin
            $display("ERR %0t: rasterizerRunning never went high", $time);
            errorCount++;
        end
        reportTest("back to back commands", startErrors);
    endtask

    task automatic testEmptyBox();
        int startErrors;
        startErrors = errorCount;
        boxX0 = 5;
        boxY0 = 5;
        boxX1 = 5;
        boxY1 = 9;
        // Edges cover everything, so any stray fragment would show
        for (int e = 0; e < 3; e++) defineEdge(e, 0, 0, 0);
        triColor = 16'($urandom);
        sendTriangle();
        releaseCmd();
        modelRender();
        commitAndCheck(1'b0);
        reportTest("empty bounding box", startErrors);
    endtask

    initial begin
        cmdTvalid     = 1'b0;
        cmdTdata      = '0;
        fbTready      = 1'b0;
        errorCount    = 0;
        testCount     = 0;
        overlapErrors = 0;
        timedOut      = 1'b0;
        watchRunning  = 1'b0;
        sawRunning    = 1'b0;
        void'($urandom(32'ha820ac22));
        waitReset();
        testClearCommit();
        testBoxOnly();
        testDiagonal();
        testRandomReady();
        testBackToBack();
        testEmptyBox();
        $display("Summary: %0d tests, %0d errors", testCount, errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
